//--- source/matmul_config.svh
// ==============================
// Dimensions, widths, SPI command codes and status bit positions
// for the SPI matrix multiplier. Include wherever these are needed
// ==============================

`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// Matrix shape and element widths
`define MM_DIM          4
`define MM_A_WIDTH      16
`define MM_B_WIDTH      8
`define MM_ACC_WIDTH    32

`define SPI_BYTE_WIDTH  8

// Command bytes, first byte of a frame
`define CMD_LOAD_A      8'h10
`define CMD_LOAD_B      8'h20
`define CMD_START       8'h30
`define CMD_READ_RES    8'h40
`define CMD_STATUS      8'h50

`define STATUS_READY_BIT 3
`define STATUS_IRQ_BIT   0

// Master keeps sclk low at least this long between bytes
`define SPI_MIN_GAP_CLKS 8

`endif

//--- source/spi_pkg.sv
// ==============================
// Types for the SPI side: bytes, commands, controller states
// ==============================

`default_nettype none

`include "matmul_config.svh"

package spi_pkg;

    typedef logic [`SPI_BYTE_WIDTH-1:0] spi_byte_t;

    typedef enum logic [7:0] {
        cmd_load_a   = `CMD_LOAD_A,
        cmd_load_b   = `CMD_LOAD_B,
        cmd_start    = `CMD_START,
        cmd_read_res = `CMD_READ_RES,
        cmd_status   = `CMD_STATUS
    } spi_cmd_e;

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_load_a,
        st_load_b,
        st_start,
        st_read_res,
        st_status,
        st_ignore
    } ctrl_state_e;

    // One received byte, valid for a single clk cycle
    typedef struct packed {
        spi_byte_t data;
        logic      valid;
    } spi_rx_t;

endpackage

`default_nettype wire

//--- source/matmul_pkg.sv
// ==============================
// Arithmetic types for the matrix engine. Element i of a matrix
// vector sits at bit i times the element width, row-major
// ==============================

`default_nettype none

`include "matmul_config.svh"

package matmul_pkg;

    typedef logic [`MM_A_WIDTH-1:0]   a_elem_t;
    typedef logic [`MM_B_WIDTH-1:0]   b_elem_t;
    typedef logic [`MM_ACC_WIDTH-1:0] acc_t;

    // Row-major element index
    typedef logic [$clog2(`MM_DIM*`MM_DIM)-1:0] elem_idx_t;

    // ==============================
    // Whole matrices as flat vectors
    // ==============================
    typedef logic [`MM_DIM*`MM_DIM*`MM_A_WIDTH-1:0]   a_matrix_t;
    typedef logic [`MM_DIM*`MM_DIM*`MM_B_WIDTH-1:0]   b_matrix_t;
    typedef logic [`MM_DIM*`MM_DIM*`MM_ACC_WIDTH-1:0] c_matrix_t;

    typedef struct packed {
        a_matrix_t a;
        b_matrix_t b;
    } mm_operands_t;

endpackage

`default_nettype wire

//--- source/spi_target.sv
// ==============================
// SPI mode 0 target. Shifts bytes in on rising sclk and out on
// falling sclk, hands each received byte over to the clk domain
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "matmul_config.svh"

module spi_target (
    input  wire logic                sclk,
    input  wire logic                mosi,
    input  wire logic                cs_n,
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire spi_pkg::spi_byte_t  tx_byte,
    output logic                     miso,
    output spi_pkg::spi_rx_t         rx,
    output logic                     frame_active
);

    logic [$clog2(`SPI_BYTE_WIDTH)-1:0] bit_cnt;
    spi_pkg::spi_byte_t                 rx_shift;
    spi_pkg::spi_byte_t                 rx_next;
    spi_pkg::spi_byte_t                 rx_hold;
    spi_pkg::spi_byte_t                 tx_shift;
    logic                               tx_msb_phase;
    logic                               byte_toggle;
    logic [2:0]                         toggle_sync;
    logic [1:0]                         cs_sync;
    logic                               byte_edge;

    // ==============================
    // SCLK domain
    // ==============================
    assign rx_next = {rx_shift[`SPI_BYTE_WIDTH-2:0], mosi};

    // Bit counter shared by receive and transmit
    always_ff @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt  <= '0;
            rx_shift <= '0;
        end else begin
            bit_cnt  <= bit_cnt + 1'b1;
            rx_shift <= rx_next;
        end
    end

    // Toggle marks a completed byte, must survive cs_n
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            byte_toggle <= 1'b0;
        end else if (bit_cnt == '1) begin
            byte_toggle <= ~byte_toggle;
        end
    end

    always_ff @(posedge sclk) begin
        if (bit_cnt == '1) begin
            rx_hold <= rx_next;
        end
    end

    // Falling edge after bit 0 sends bit 6 onwards
    always_ff @(negedge sclk) begin
        if (bit_cnt == 1) begin
            tx_shift <= {tx_byte[`SPI_BYTE_WIDTH-2:0], 1'b0};
        end else begin
            tx_shift <= {tx_shift[`SPI_BYTE_WIDTH-2:0], 1'b0};
        end
    end

    // High until the first falling edge of a byte
    always_ff @(negedge sclk or posedge cs_n) begin
        if (cs_n) begin
            tx_msb_phase <= 1'b1;
        end else begin
            tx_msb_phase <= (bit_cnt == '0);
        end
    end

    assign miso = !cs_n && (tx_msb_phase ? tx_byte[`SPI_BYTE_WIDTH-1]
                                         : tx_shift[`SPI_BYTE_WIDTH-1]);

    // ==============================
    // CLK domain
    // ==============================
    assign byte_edge    = toggle_sync[2] ^ toggle_sync[1];
    assign frame_active = cs_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle_sync <= '0;
            cs_sync     <= '0;
            rx          <= '0;
        end else begin
            toggle_sync <= {toggle_sync[1:0], byte_toggle};
            cs_sync     <= {cs_sync[0], ~cs_n};
            rx.valid    <= byte_edge;
            // rx_hold is stable for a whole byte time here
            if (byte_edge) begin
                rx.data <= rx_hold;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/command_controller.sv
// ==============================
// Command FSM. Decodes the first byte of a frame, stores operands,
// starts the engine and serves results and status over SPI
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "matmul_config.svh"

module command_controller (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire spi_pkg::spi_rx_t      rx,
    input  wire logic                  frame_active,
    input  wire logic                  done,
    input  wire matmul_pkg::c_matrix_t results,
    output spi_pkg::spi_byte_t         tx_byte,
    output matmul_pkg::mm_operands_t   operands,
    output logic                       start,
    output logic                       irq
);

    spi_pkg::ctrl_state_e  state;
    spi_pkg::spi_cmd_e     cmd_q;
    matmul_pkg::elem_idx_t elem_idx;
    logic [1:0]            byte_idx;
    logic [4:0]            a_addr;
    logic [5:0]            res_addr;
    logic                  last_elem;
    logic                  first_res_byte;
    logic                  results_ready;
    spi_pkg::spi_byte_t    status_byte;

    // Byte addresses into A and into the result vector
    assign a_addr    = {elem_idx, byte_idx[0]};
    assign res_addr  = {elem_idx, byte_idx};
    assign last_elem = (elem_idx == '1);

    // Byte 0 is preloaded at decode, so address 1 means first byte received
    assign first_res_byte = (state == spi_pkg::st_read_res) && rx.valid && (res_addr == 6'd1);

    always_comb begin
        status_byte = '0;
        status_byte[`STATUS_READY_BIT] = results_ready;
        status_byte[`STATUS_IRQ_BIT]   = irq;
    end

    always_ff @(posedge clk) begin
        if (state == spi_pkg::st_idle && rx.valid) begin
            cmd_q <= spi_pkg::spi_cmd_e'(rx.data);
        end
    end

    // Operand storage
    always_ff @(posedge clk) begin
        if (rx.valid && state == spi_pkg::st_load_a) begin
            operands.a[a_addr*`SPI_BYTE_WIDTH +: `SPI_BYTE_WIDTH] <= rx.data;
        end
        if (rx.valid && state == spi_pkg::st_load_b) begin
            operands.b[elem_idx*`MM_B_WIDTH +: `MM_B_WIDTH] <= rx.data;
        end
    end

    // ==============================
    // Frame FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= spi_pkg::st_idle;
            elem_idx <= '0;
            byte_idx <= '0;
            tx_byte  <= '0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            if (!frame_active) begin
                state   <= spi_pkg::st_idle;
                tx_byte <= '0;
            end else begin
                case (state)
                    spi_pkg::st_idle: begin
                        if (rx.valid) begin
                            state <= spi_pkg::st_decode;
                        end
                    end
                    spi_pkg::st_decode: begin
                        elem_idx <= '0;
                        byte_idx <= '0;
                        case (cmd_q)
                            spi_pkg::cmd_load_a: state <= spi_pkg::st_load_a;
                            spi_pkg::cmd_load_b: state <= spi_pkg::st_load_b;
                            spi_pkg::cmd_start: begin
                                state <= spi_pkg::st_start;
                                start <= 1'b1;
                            end
                            spi_pkg::cmd_read_res: begin
                                state    <= spi_pkg::st_read_res;
                                tx_byte  <= results[`SPI_BYTE_WIDTH-1:0];
                                byte_idx <= 2'd1;
                            end
                            spi_pkg::cmd_status: begin
                                state   <= spi_pkg::st_status;
                                tx_byte <= status_byte;
                            end
                            default: state <= spi_pkg::st_ignore;
                        endcase
                    end
                    spi_pkg::st_load_a: begin
                        // Low byte then high byte per element
                        if (rx.valid) begin
                            byte_idx <= {1'b0, ~byte_idx[0]};
                            if (byte_idx[0]) begin
                                elem_idx <= elem_idx + 1'b1;
                                if (last_elem) begin
                                    state <= spi_pkg::st_ignore;
                                end
                            end
                        end
                    end
                    spi_pkg::st_load_b: begin
                        if (rx.valid) begin
                            elem_idx <= elem_idx + 1'b1;
                            if (last_elem) begin
                                state <= spi_pkg::st_ignore;
                            end
                        end
                    end
                    spi_pkg::st_start: begin
                        state <= spi_pkg::st_ignore;
                    end
                    spi_pkg::st_read_res: begin
                        if (rx.valid) begin
                            tx_byte <= results[res_addr*`SPI_BYTE_WIDTH +: `SPI_BYTE_WIDTH];
                            {elem_idx, byte_idx} <= res_addr + 6'd1;
                        end
                    end
                    spi_pkg::st_status: begin
                        if (rx.valid) begin
                            tx_byte <= status_byte;
                        end
                    end
                    spi_pkg::st_ignore: begin
                        state <= spi_pkg::st_ignore;
                    end
                    default: state <= spi_pkg::st_idle;
                endcase
            end
        end
    end

    // Result and interrupt flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            results_ready <= 1'b0;
            irq           <= 1'b0;
        end else begin
            if (done) begin
                results_ready <= 1'b1;
            end else if (start) begin
                results_ready <= 1'b0;
            end
            if (done) begin
                irq <= 1'b1;
            end else if (first_res_byte) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/matmul_engine.sv
// ==============================
// Sequential 4x4 multiply-accumulate engine. One MAC per cycle,
// done pulses 65 cycles after an accepted start
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "matmul_config.svh"

module matmul_engine (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start,
    input  wire matmul_pkg::mm_operands_t operands,
    output logic                          done,
    output matmul_pkg::c_matrix_t         results
);

    typedef logic [$clog2(`MM_DIM)-1:0] dim_idx_t;

    localparam dim_idx_t last_idx = dim_idx_t'(`MM_DIM - 1);

    dim_idx_t              row;
    dim_idx_t              col;
    dim_idx_t              k;
    logic                  busy;
    logic                  last_step;
    matmul_pkg::elem_idx_t a_idx;
    matmul_pkg::elem_idx_t b_idx;
    matmul_pkg::elem_idx_t c_idx;
    matmul_pkg::a_elem_t   a_cur;
    matmul_pkg::b_elem_t   b_cur;
    matmul_pkg::acc_t      product;
    matmul_pkg::acc_t      sum;
    matmul_pkg::acc_t      acc;

    // A[row][k] * B[k][col]
    assign a_idx = matmul_pkg::elem_idx_t'(row * `MM_DIM + k);
    assign b_idx = matmul_pkg::elem_idx_t'(k * `MM_DIM + col);
    assign c_idx = matmul_pkg::elem_idx_t'(row * `MM_DIM + col);

    assign a_cur   = operands.a[a_idx*`MM_A_WIDTH +: `MM_A_WIDTH];
    assign b_cur   = operands.b[b_idx*`MM_B_WIDTH +: `MM_B_WIDTH];
    assign product = matmul_pkg::acc_t'(a_cur) * matmul_pkg::acc_t'(b_cur);
    assign sum     = ((k == '0) ? '0 : acc) + product;

    assign last_step = (row == last_idx) && (col == last_idx) && (k == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            row  <= '0;
            col  <= '0;
            k    <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    row  <= '0;
                    col  <= '0;
                    k    <= '0;
                end
            end else begin
                k <= (k == last_idx) ? '0 : k + 1'b1;
                if (k == last_idx) begin
                    col <= (col == last_idx) ? '0 : col + 1'b1;
                    if (col == last_idx) begin
                        row <= (row == last_idx) ? '0 : row + 1'b1;
                    end
                end
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Finished sum goes straight to its result slot
    always_ff @(posedge clk) begin
        if (busy) begin
            acc <= sum;
            if (k == last_idx) begin
                results[c_idx*`MM_ACC_WIDTH +: `MM_ACC_WIDTH] <= sum;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/spi_matmul_top.sv
// ==============================
// Top level of the SPI matrix multiplier
// ==============================

`timescale 1ns/1ps
`default_nettype none

module spi_matmul_top (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic sclk,
    input  wire logic mosi,
    input  wire logic cs_n,
    output logic      miso,
    output logic      irq
);

    spi_pkg::spi_rx_t         rx;
    spi_pkg::spi_byte_t       tx_byte;
    logic                     frame_active;
    matmul_pkg::mm_operands_t operands;
    matmul_pkg::c_matrix_t    results;
    logic                     start;
    logic                     done;

    spi_target spi_target_inst (
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n),
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_byte      (tx_byte),
        .miso         (miso),
        .rx           (rx),
        .frame_active (frame_active)
    );

    command_controller command_controller_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .frame_active (frame_active),
        .done         (done),
        .results      (results),
        .tx_byte      (tx_byte),
        .operands     (operands),
        .start        (start),
        .irq          (irq)
    );

    matmul_engine matmul_engine_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .operands (operands),
        .done     (done),
        .results  (results)
    );

endmodule

`default_nettype wire

//--- verification/spi_matmul_properties.sv
// ==============================
// Concurrent checks on the SPI matrix multiplier, bound to the
// top level so they watch its internal handshakes
// ==============================

`timescale 1ns/1ps
`default_nettype none

module spi_matmul_properties (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire spi_pkg::spi_rx_t rx,
    input wire logic             start,
    input wire logic             done,
    input wire logic             irq,
    input wire logic             sclk,
    input wire logic             miso,
    input wire logic             frame_active
);

    rx_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx.valid |=> !rx.valid)
        else $error("rx.valid high in two consecutive cycles");

    start_single: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !start)
        else $error("start held high longer than one cycle");

    // Idle line, no frame and sclk low
    miso_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        (!frame_active && !sclk) |-> !miso)
        else $error("miso driven high outside a frame");

    irq_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> $past(done))
        else $error("irq rose without a preceding done");

endmodule

bind spi_matmul_top spi_matmul_properties spi_matmul_properties_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .start        (start),
    .done         (done),
    .irq          (irq),
    .sclk         (sclk),
    .miso         (miso),
    .frame_active (frame_active)
);

`default_nettype wire

//--- verification/spi_matmul_tb.sv
// ==============================
// Testbench for the SPI matrix multiplier. Acts as SPI master,
// takes operands and expected results from the stimulus file
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "matmul_config.svh"

module spi_matmul_tb;

    localparam int clk_period    = 40;
    localparam int half_clks     = 4;
    localparam int gap_clks      = `SPI_MIN_GAP_CLKS + 4;
    localparam int byte_clks     = 2 * half_clks * `SPI_BYTE_WIDTH + gap_clks;
    localparam int elem_count    = `MM_DIM * `MM_DIM;
    localparam int set_words     = 3 * elem_count;
    localparam int num_sets      = 3;
    localparam int acc_bytes     = `MM_ACC_WIDTH / `SPI_BYTE_WIDTH;
    localparam int set_bytes     = 120;
    localparam int irq_limit     = 200;
    // Three sets plus the reset and abort sequences, with margin
    localparam int watchdog_clks = 2 * (num_sets + 2) * (set_bytes * byte_clks + irq_limit);

    logic clk = 1'b0;
    logic rst_n;
    logic sclk;
    logic mosi;
    logic cs_n;
    logic miso;
    logic irq;

    logic [31:0] stim_mem [0:num_sets*set_words-1];

    spi_matmul_top spi_matmul_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .sclk  (sclk),
        .mosi  (mosi),
        .cs_n  (cs_n),
        .miso  (miso),
        .irq   (irq)
    );

    always #(clk_period / 2) clk = ~clk;

    // ==============================
    // Result checks
    // ==============================
    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_result(input string name, input matmul_pkg::acc_t expected,
                                input matmul_pkg::acc_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_status(input string name, input spi_pkg::spi_byte_t expected,
                                input spi_pkg::spi_byte_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_irq(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", name, expected, actual);
            fail_run();
        end
    endtask

    // ==============================
    // SPI master, mode 0
    // ==============================
    // Starts and ends right after a rising clk edge
    task automatic spi_transfer(input spi_pkg::spi_byte_t send,
                                output spi_pkg::spi_byte_t received);
        spi_pkg::spi_byte_t shift_in;
        int bit_pos;
        shift_in = '0;
        for (bit_pos = `SPI_BYTE_WIDTH - 1; bit_pos >= 0; bit_pos--) begin
            mosi <= send[bit_pos];
            repeat (half_clks) @(posedge clk);
            sclk <= 1'b1;
            shift_in[bit_pos] = miso;
            repeat (half_clks) @(posedge clk);
            sclk <= 1'b0;
        end
        repeat (gap_clks) @(posedge clk);
        received = shift_in;
    endtask

    task automatic frame_open();
        cs_n <= 1'b0;
        repeat (gap_clks) @(posedge clk);
    endtask

    task automatic frame_close();
        cs_n <= 1'b1;
        repeat (gap_clks) @(posedge clk);
    endtask

    task automatic load_a(input int set_idx);
        spi_pkg::spi_byte_t  discard;
        matmul_pkg::a_elem_t elem;
        int e;
        frame_open();
        spi_transfer(spi_pkg::cmd_load_a, discard);
        for (e = 0; e < elem_count; e++) begin
            elem = stim_mem[set_idx*set_words + e][`MM_A_WIDTH-1:0];
            spi_transfer(elem[`SPI_BYTE_WIDTH-1:0], discard);
            spi_transfer(elem[`MM_A_WIDTH-1:`SPI_BYTE_WIDTH], discard);
        end
        frame_close();
    endtask

    task automatic load_b(input int set_idx);
        spi_pkg::spi_byte_t discard;
        int e;
        frame_open();
        spi_transfer(spi_pkg::cmd_load_b, discard);
        for (e = 0; e < elem_count; e++) begin
            spi_transfer(stim_mem[set_idx*set_words + elem_count + e][`MM_B_WIDTH-1:0],
                         discard);
        end
        frame_close();
    endtask

    task automatic start_multiply();
        spi_pkg::spi_byte_t discard;
        frame_open();
        spi_transfer(spi_pkg::cmd_start, discard);
        frame_close();
    endtask

    task automatic wait_irq(input string name);
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < irq_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (irq !== 1'b1) begin
            $display("%s: irq did not rise within %0d clk cycles after start", name, irq_limit);
            fail_run();
        end
    endtask

    task automatic read_status(output spi_pkg::spi_byte_t status);
        spi_pkg::spi_byte_t discard;
        logic [31:0]        rand_word;
        frame_open();
        spi_transfer(spi_pkg::cmd_status, discard);
        rand_word = $urandom;
        spi_transfer(rand_word[`SPI_BYTE_WIDTH-1:0], status);
        frame_close();
    endtask

    task automatic read_results(input int set_idx, input string name);
        spi_pkg::spi_byte_t discard;
        spi_pkg::spi_byte_t rx_byte;
        matmul_pkg::acc_t   value;
        logic [31:0]        rand_word;
        int base;
        int e;
        int b;
        base = set_idx*set_words + 2*elem_count;
        frame_open();
        spi_transfer(spi_pkg::cmd_read_res, discard);
        for (e = 0; e < elem_count; e++) begin
            value = '0;
            for (b = 0; b < acc_bytes; b++) begin
                rand_word = $urandom;
                spi_transfer(rand_word[`SPI_BYTE_WIDTH-1:0], rx_byte);
                value[b*`SPI_BYTE_WIDTH +: `SPI_BYTE_WIDTH] = rx_byte;
                if (e == 0 && b == 0) begin
                    check_irq({name, " irq after first result byte"}, 1'b0, irq);
                end
            end
            check_result($sformatf("%s C[%0d]", name, e), stim_mem[base + e], value);
        end
        frame_close();
    endtask

    // Load, multiply, read back and check one set
    task automatic run_set(input int set_idx, input string name);
        spi_pkg::spi_byte_t status;
        load_a(set_idx);
        load_b(set_idx);
        start_multiply();
        wait_irq(name);
        read_status(status);
        check_status({name, " status after multiply"}, 8'h09, status);
        read_results(set_idx, name);
        read_status(status);
        check_status({name, " status after read"}, 8'h08, status);
    endtask

    // Unknown code, then bytes that look like commands
    task automatic send_unknown_command();
        spi_pkg::spi_byte_t discard;
        frame_open();
        spi_transfer(8'h77, discard);
        spi_transfer(spi_pkg::cmd_start, discard);
        spi_transfer(spi_pkg::cmd_load_a, discard);
        spi_transfer(spi_pkg::cmd_load_b, discard);
        spi_transfer(spi_pkg::cmd_read_res, discard);
        frame_close();
    endtask

    // Load A cut off after 10 bytes
    task automatic load_a_aborted();
        spi_pkg::spi_byte_t discard;
        int n;
        frame_open();
        spi_transfer(spi_pkg::cmd_load_a, discard);
        for (n = 0; n < 9; n++) begin
            spi_transfer(8'hA5, discard);
        end
        frame_close();
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        spi_pkg::spi_byte_t status;
        int set_idx;
        rst_n <= 1'b0;
        cs_n  <= 1'b1;
        sclk  <= 1'b0;
        mosi  <= 1'b0;
        void'($urandom(32'h831d77a3));
        $readmemh("verification/spi_matmul_stimulus.txt", stim_mem);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (gap_clks) @(posedge clk);

        check_irq("irq after reset", 1'b0, irq);
        read_status(status);
        check_status("status after reset", 8'h00, status);

        for (set_idx = 0; set_idx < num_sets; set_idx++) begin
            run_set(set_idx, $sformatf("set %0d", set_idx));
        end

        send_unknown_command();
        read_status(status);
        check_status("status after unknown command", 8'h08, status);
        check_irq("irq after unknown command", 1'b0, irq);

        load_a_aborted();
        run_set(0, "set 0 after aborted load");

        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_clks) @(posedge clk);
        $display("timeout, the tests did not finish within %0d clk cycles", watchdog_clks);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- verification/spi_matmul_stimulus.txt
// Per set: 16 A elements (16 bit), 16 B elements (8 bit), 16 expected C elements (32 bit)
// Hex, row-major, whitespace separated, sets follow each other
// Set 0: A and B both hold 1..16
0001 0002 0003 0004 0005 0006 0007 0008
0009 000A 000B 000C 000D 000E 000F 0010
01 02 03 04 05 06 07 08
09 0A 0B 0C 0D 0E 0F 10
0000005A 00000064 0000006E 00000078 000000CA 000000E4 000000FE 00000118
0000013A 00000164 0000018E 000001B8 000001AA 000001E4 0000021E 00000258
// Set 1: diagonal A with wide elements, dense B
1234 0000 0000 0000 0000 ABCD 0000 0000
0000 0000 FFFF 0000 0000 0000 0000 8000
11 22 33 44 55 66 77 88
99 AA BB CC DD EE FF 01
00013574 00026AE8 0003A05C 0004D5D0 00390B11 004473AE 004FDC4B 005B44E8
0098FF67 00A9FF56 00BAFF45 00CBFF34 006E8000 00770000 007F8000 00008000
// Set 2: all elements at their maximum
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04
03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04

//--- files.f
+incdir+source
source/spi_pkg.sv
source/matmul_pkg.sv
source/spi_target.sv
source/command_controller.sv
source/matmul_engine.sv
source/spi_matmul_top.sv
verification/spi_matmul_properties.sv
verification/spi_matmul_tb.sv

//--- Bender.yml
package:
  name: spi_matmul

sources:
  - include_dirs:
      - source
    files:
      - source/spi_pkg.sv
      - source/matmul_pkg.sv
      - source/spi_target.sv
      - source/command_controller.sv
      - source/matmul_engine.sv
      - source/spi_matmul_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/spi_matmul_properties.sv
      - verification/spi_matmul_tb.sv
